/* tb.f */
+incdir+.
mul_pkg.sv
ctrl_pkg.sv
mul_cfg_regs.sv
booth_pp_gen.sv
wallace_csa_tree.sv
carry_prop_adder.sv
mul_pipeline.sv
mul_unit.sv
tb_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mul_unit -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 ; \
grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module tb_mul_unit;

    localparam int EXP_LAT = 3; // edges from request sample to registered result.
    localparam int TIMEOUT = 32;

    // each entry is {a, b}.
    localparam logic [31:0] SIGNED_CORNERS [12] = '{
        32'h0000_0000, 32'h0000_0001, 32'h0001_0001, 32'h0001_ffff,
        32'hffff_ffff, 32'hffff_0001, 32'h8000_8000, 32'h8000_7fff,
        32'h7fff_7fff, 32'h7fff_8000, 32'hffff_8000, 32'h0000_8000
    };
    localparam logic [31:0] UNSIGNED_CORNERS [4] = '{
        32'hffff_ffff, 32'hffff_0001, 32'h0000_0000, 32'h8000_8000
    };

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_cfg_we;
    ctrl_pkg::mul_cfg_t    i_cfg;
    logic                  i_valid;
    mul_pkg::mul_req_t     i_req;
    logic                  o_valid;
    mul_pkg::mul_rsp_t     o_rsp;
    ctrl_pkg::mul_status_t o_status;

    mul_pkg::mul_rsp_t     exp_q [$];
    mul_pkg::mul_rsp_t     mon_exp;
    ctrl_pkg::mul_status_t exp_status;
    logic [31:0]           lcg_state;
    logic                  mode_model; // mode the next sampled request will use.
    logic [`MUL_TAG_W-1:0] next_tag;
    int                    check_cnt;
    int                    err_cnt;
    int                    pulse_cnt;
    int                    req_cnt;
    int                    test_err;

    mul_unit u_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_cfg_we (i_cfg_we),
        .i_cfg    (i_cfg),
        .i_valid  (i_valid),
        .i_req    (i_req),
        .o_valid  (o_valid),
        .o_rsp    (o_rsp),
        .o_status (o_status)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // full 64-bit product, reduced to 32 bits.
    function automatic logic [31:0] model_product(input logic [15:0] a, input logic [15:0] b,
                                                  input logic sgn);
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        xa = sgn ? {{48{a[15]}}, a} : {48'd0, a};
        xb = sgn ? {{48{b[15]}}, b} : {48'd0, b};
        p  = xa * xb;
        return p[31:0];
    endfunction

    function automatic mul_pkg::mul_req_t make_req(input logic [15:0] a, input logic [15:0] b);
        mul_pkg::mul_req_t req;
        req.a    = a;
        req.b    = b;
        req.tag  = next_tag;
        next_tag = next_tag + 1'b1;
        req_cnt++;
        return req;
    endfunction

    task automatic note_mismatch(input string msg);
        err_cnt++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic check_rsp(input mul_pkg::mul_rsp_t got, input mul_pkg::mul_rsp_t exp);
        check_cnt++;
        if (got !== exp) begin
            note_mismatch($sformatf("product %h tag %h, expected product %h tag %h",
                                    got.product, got.tag, exp.product, exp.tag));
        end
    endtask

    task automatic check_status(input ctrl_pkg::mul_status_t got,
                                input ctrl_pkg::mul_status_t exp);
        check_cnt++;
        if (got !== exp) begin
            note_mismatch($sformatf("done_count %0d, expected %0d",
                                    got.done_count, exp.done_count));
        end
    endtask

    task automatic drive_cycle(input logic valid, input mul_pkg::mul_req_t req,
                               input logic we, input logic sgn);
        mul_pkg::mul_rsp_t rsp;
        @(posedge i_clk);
        i_valid         <= valid;
        i_req           <= req;
        i_cfg_we        <= we;
        i_cfg.is_signed <= sgn;
        if (valid) begin
            rsp.product = model_product(req.a, req.b, mode_model);
            rsp.tag     = req.tag;
            exp_q.push_back(rsp);
        end
        if (we) begin
            mode_model = sgn; // later requests see the new mode.
        end
    endtask

    task automatic send_req(input logic [15:0] a, input logic [15:0] b);
        drive_cycle(1'b1, make_req(a, b), 1'b0, mode_model);
    endtask

    task automatic go_idle();
        drive_cycle(1'b0, '0, 1'b0, mode_model);
    endtask

    task automatic write_mode(input logic sgn);
        drive_cycle(1'b0, '0, 1'b1, sgn);
    endtask

    task automatic run_random(input int count);
        int          sent;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        sent = 0;
        while (sent < count) begin
            r0 = lcg_next();
            if (r0[31:30] == 2'b00) begin
                go_idle(); // random gap.
            end else begin
                r1 = lcg_next();
                r2 = lcg_next();
                send_req(r1[31:16], r2[31:16]);
                sent++;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (exp_q.size() != 0 && n < TIMEOUT);
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("timeout at %0t: %0d results never came back", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, err_cnt - test_err);
        test_err = err_cnt;
    endtask

    // results are taken at the edge, using the values held through the cycle.
    always @(posedge i_clk) begin
        if (i_rst_n && o_valid) begin
            pulse_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected result at %0t with no request outstanding", $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check_rsp(o_rsp, mon_exp);
            end
        end
    end

    initial begin
        int          i;
        int          lat;
        logic [31:0] r1;
        logic [31:0] r2;
        i_rst_n    = 1'b0;
        i_cfg_we   = 1'b0;
        i_cfg      = '0;
        i_valid    = 1'b0;
        i_req      = '0;
        lcg_state  = 32'd15;
        mode_model = 1'b0; // unsigned after reset.
        next_tag   = '0;
        check_cnt  = 0;
        err_cnt    = 0;
        pulse_cnt  = 0;
        req_cnt    = 0;
        test_err   = 0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;

        repeat (6) begin
            @(negedge i_clk);
            check_cnt++;
            if (o_valid !== 1'b0) begin
                note_mismatch("o_valid high while idle after reset");
            end
            check_status(o_status, '0);
        end
        end_test("reset");

        write_mode(1'b1);
        for (i = 0; i < 12; i++) begin
            send_req(SIGNED_CORNERS[i][31:16], SIGNED_CORNERS[i][15:0]);
        end
        run_random(200);
        go_idle();
        wait_drain();
        end_test("signed");

        write_mode(1'b0);
        for (i = 0; i < 4; i++) begin
            send_req(UNSIGNED_CORNERS[i][31:16], UNSIGNED_CORNERS[i][15:0]);
        end
        run_random(200);
        go_idle();
        wait_drain();
        end_test("unsigned");

        send_req(16'd1234, 16'd56);
        go_idle(); // request sampled at this edge.
        lat = 0;
        do begin
            @(negedge i_clk);
            lat++;
        end while (o_valid !== 1'b1 && lat < TIMEOUT);
        check_cnt++;
        if (o_valid !== 1'b1) begin
            err_cnt++;
            $display("timeout at %0t: isolated request never produced o_valid", $time);
        end else if (lat != EXP_LAT) begin
            note_mismatch($sformatf("latency %0d edges, expected %0d", lat, EXP_LAT));
        end
        wait_drain();
        end_test("latency");

        for (i = 0; i < 64; i++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            if (i == 20 || i == 41) begin
                // mode write shares the cycle with a request.
                drive_cycle(1'b1, make_req(r1[31:16], r2[31:16]), 1'b1, ~mode_model);
            end else begin
                send_req(r1[31:16], r2[31:16]);
            end
        end
        go_idle();
        wait_drain();
        end_test("stream");

        @(negedge i_clk);
        exp_status.done_count = pulse_cnt[`MUL_CNT_W-1:0];
        check_status(o_status, exp_status);
        if (pulse_cnt != req_cnt) begin
            err_cnt++;
            $display("%0d requests sent but %0d results seen", req_cnt, pulse_cnt);
        end
        end_test("status");

        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_unit (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_cfg_we,
    input  ctrl_pkg::mul_cfg_t     i_cfg,
    input  logic                   i_valid,
    input  mul_pkg::mul_req_t      i_req,
    output logic                   o_valid,
    output mul_pkg::mul_rsp_t      o_rsp,
    output ctrl_pkg::mul_status_t  o_status
);

    ctrl_pkg::mul_cfg_t w_cfg;

    mul_cfg_regs u_cfg_regs (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_cfg_we (i_cfg_we),
        .i_cfg    (i_cfg),
        .i_done   (o_valid), // one pulse per product.
        .o_cfg    (w_cfg),
        .o_status (o_status)
    );

    mul_pipeline u_pipe (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_req   (i_req),
        .i_cfg   (w_cfg),
        .o_valid (o_valid),
        .o_rsp   (o_rsp)
    );

endmodule

`default_nettype wire

/* mul_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_pipeline (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_valid,
    input  mul_pkg::mul_req_t   i_req,
    input  ctrl_pkg::mul_cfg_t  i_cfg,
    output logic                o_valid,
    output mul_pkg::mul_rsp_t   o_rsp
);

    mul_pkg::pp_rows_t      w_rows;
    mul_pkg::csa_pair_t     w_pair;
    logic [`MUL_PROD_W-1:0] w_product;

    logic                   r1_valid;
    logic [`MUL_TAG_W-1:0]  r1_tag;
    mul_pkg::pp_rows_t      r1_rows;

    logic                   r2_valid;
    logic [`MUL_TAG_W-1:0]  r2_tag;
    mul_pkg::csa_pair_t     r2_pair;

    logic                   r3_valid;
    mul_pkg::mul_rsp_t      r3_rsp;

    // mode is used here, so later cfg writes cannot reach this request.
    booth_pp_gen u_booth (
        .i_mcand     (i_req.a),
        .i_mplier    (i_req.b),
        .i_is_signed (i_cfg.is_signed),
        .o_rows      (w_rows)
    );

    wallace_csa_tree u_tree (
        .i_rows (r1_rows),
        .o_pair (w_pair)
    );

    carry_prop_adder u_cpa (
        .i_pair (r2_pair),
        .o_sum  (w_product)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r1_valid <= 1'b0;
            r2_valid <= 1'b0;
            r3_valid <= 1'b0;
        end else begin
            r1_valid <= i_valid;
            r2_valid <= r1_valid;
            r3_valid <= r2_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        r1_tag         <= i_req.tag;
        r1_rows        <= w_rows;
        r2_tag         <= r1_tag;
        r2_pair        <= w_pair;
        r3_rsp.product <= w_product;
        r3_rsp.tag     <= r2_tag;
    end

    assign o_valid = r3_valid;
    assign o_rsp   = r3_rsp;

endmodule

`default_nettype wire

/* carry_prop_adder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module carry_prop_adder (
    input  mul_pkg::csa_pair_t      i_pair,
    output logic [`MUL_PROD_W-1:0]  o_sum
);

    logic [`MUL_PROD_W-1:0] w_cry; // carry into each bit.

    assign w_cry[0] = 1'b0;

    genvar i;
    generate
        for (i = 0; i < `MUL_PROD_W; i = i + 1) begin : g_fa
            logic w_a;
            logic w_b;

            assign w_a      = i_pair.sum[i];
            assign w_b      = i_pair.carry[i];
            assign o_sum[i] = w_a ^ w_b ^ w_cry[i];

            if (i < `MUL_PROD_W - 1) begin : g_cry
                assign w_cry[i+1] = (w_a & w_b) | (w_cry[i] & (w_a ^ w_b));
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* wallace_csa_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module wallace_csa_tree (
    input  mul_pkg::pp_rows_t  i_rows,
    output mul_pkg::csa_pair_t o_pair
);

    // one 3:2 compressor across the full row width.
    function automatic mul_pkg::csa_pair_t csa(
        input logic [`MUL_PROD_W-1:0] a,
        input logic [`MUL_PROD_W-1:0] b,
        input logic [`MUL_PROD_W-1:0] c
    );
        mul_pkg::csa_pair_t r;
        r.sum   = a ^ b ^ c;
        r.carry = ((a & b) | (a & c) | (b & c)) << 1; // top carry falls off.
        return r;
    endfunction

    mul_pkg::csa_pair_t w_l1 [3];
    mul_pkg::csa_pair_t w_l2 [2];
    mul_pkg::csa_pair_t w_l3;
    mul_pkg::csa_pair_t w_l4;

    // layer 1: 9 -> 6.
    genvar g;
    generate
        for (g = 0; g < 3; g = g + 1) begin : g_l1
            assign w_l1[g] = csa(i_rows[3*g], i_rows[3*g+1], i_rows[3*g+2]);
        end
    endgenerate

    // layer 2: 6 -> 4.
    assign w_l2[0] = csa(w_l1[0].sum,   w_l1[0].carry, w_l1[1].sum);
    assign w_l2[1] = csa(w_l1[1].carry, w_l1[2].sum,   w_l1[2].carry);

    // layer 3: 4 -> 3, w_l2[1].carry passes to the next layer.
    assign w_l3 = csa(w_l2[0].sum, w_l2[0].carry, w_l2[1].sum);

    // layer 4: 3 -> 2.
    assign w_l4 = csa(w_l3.sum, w_l3.carry, w_l2[1].carry);

    assign o_pair = w_l4;

endmodule

`default_nettype wire

/* booth_pp_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module booth_pp_gen (
    input  logic [`MUL_OP_W-1:0] i_mcand,
    input  logic [`MUL_OP_W-1:0] i_mplier,
    input  logic                 i_is_signed,
    output mul_pkg::pp_rows_t    o_rows
);

    localparam int EXT_PAD  = `MUL_EXT_W - `MUL_OP_W;
    localparam int FULL_PAD = `MUL_PROD_W - `MUL_EXT_W;

    logic                    w_x_sign;
    logic                    w_y_sign;
    logic [`MUL_EXT_W-1:0]   w_x_ext;
    logic [`MUL_EXT_W:0]     w_y_app;
    logic [`MUL_PROD_W-1:0]  w_x_full;

    assign w_x_sign = i_is_signed & i_mcand[`MUL_OP_W-1];
    assign w_y_sign = i_is_signed & i_mplier[`MUL_OP_W-1];

    assign w_x_ext  = {{EXT_PAD{w_x_sign}}, i_mcand};
    assign w_y_app  = {{EXT_PAD{w_y_sign}}, i_mplier, 1'b0}; // implicit y[-1].
    assign w_x_full = {{FULL_PAD{w_x_ext[`MUL_EXT_W-1]}}, w_x_ext};

    genvar i;
    generate
        for (i = 0; i < `MUL_PP_N; i = i + 1) begin : g_digit
            logic [2:0]             w_win;
            logic                   w_one;
            logic                   w_two;
            logic                   w_neg;
            logic [`MUL_PROD_W-1:0] w_sel;
            logic [`MUL_PROD_W-1:0] w_mag;

            assign w_win = w_y_app[2*i +: 3];

            // radix-4 recoding of the window.
            assign w_one = w_win[1] ^ w_win[0];
            assign w_two = (w_win == 3'b011) | (w_win == 3'b100);
            assign w_neg = w_win[2] & ~(w_win[1] & w_win[0]);

            assign w_sel = w_two ? (w_x_full << 1) : (w_one ? w_x_full : '0);
            assign w_mag = w_sel ^ {`MUL_PROD_W{w_neg}}; // ones complement.

            // the +1 lands at bit 2*i after the shift.
            assign o_rows[i] = (w_mag + {{(`MUL_PROD_W-1){1'b0}}, w_neg}) << (2 * i);
        end
    endgenerate

endmodule

`default_nettype wire

/* mul_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_cfg_regs (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_cfg_we,
    input  ctrl_pkg::mul_cfg_t     i_cfg,
    input  logic                   i_done,
    output ctrl_pkg::mul_cfg_t     o_cfg,
    output ctrl_pkg::mul_status_t  o_status
);

    ctrl_pkg::mul_cfg_t    r_cfg;
    ctrl_pkg::mul_status_t r_status;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_cfg <= '0; // unsigned after reset.
        end else if (i_cfg_we) begin
            r_cfg <= i_cfg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_status <= '0;
        end else if (i_done) begin
            r_status.done_count <= r_status.done_count + {{(`MUL_CNT_W-1){1'b0}}, 1'b1};
        end
    end

    assign o_cfg    = r_cfg;
    assign o_status = r_status;

endmodule

`default_nettype wire

/* ctrl_pkg.sv */
`default_nettype none

`include "mul_defs.svh"

package ctrl_pkg;

    typedef struct packed {
        logic is_signed; // 0 selects unsigned operands.
    } mul_cfg_t;

    typedef struct packed {
        logic [`MUL_CNT_W-1:0] done_count; // wraps.
    } mul_status_t;

endpackage

`default_nettype wire

/* mul_pkg.sv */
`default_nettype none

`include "mul_defs.svh"

package mul_pkg;

    typedef struct packed {
        logic [`MUL_OP_W-1:0]  a;
        logic [`MUL_OP_W-1:0]  b;
        logic [`MUL_TAG_W-1:0] tag;
    } mul_req_t;

    typedef struct packed {
        logic [`MUL_PROD_W-1:0] product;
        logic [`MUL_TAG_W-1:0]  tag;
    } mul_rsp_t;

    // rows are already shifted into product alignment.
    typedef logic [`MUL_PP_N-1:0][`MUL_PROD_W-1:0] pp_rows_t;

    typedef struct packed {
        logic [`MUL_PROD_W-1:0] sum;
        logic [`MUL_PROD_W-1:0] carry;
    } csa_pair_t;

endpackage

`default_nettype wire

/* mul_defs.svh */
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// operand and product sizes.
`define MUL_OP_W   16
`define MUL_PROD_W 32
`define MUL_EXT_W  18 // one extra bit keeps unsigned operands positive.
`define MUL_PP_N   9

`define MUL_TAG_W  4
`define MUL_CNT_W  16

`endif
